// ==== include/mem_macros.svh ====
// memory subsystem size and timing constants, included by the package and every RTL file that sizes logic
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// cycles from an accepted request to its read data at the memory output
`define MEM_LATENCY 4

// words fetched for one cache block fill
// must stay a power of two, the fill index wraps at the block end
`define BLOCK_WORDS 4

// word address bits actually decoded by the memory array
// upper address bits are ignored
`define MEM_ADDR_BITS 10

// data word and address width of the processor
`define WORD_BITS 16

`endif

// ==== design/mem_pkg.sv ====
// shared types for the memory subsystem; RTL imports it by wildcard in the body, ports use mem_pkg:: names
`include "mem_macros.svh"

package mem_pkg;

    // who owns an access on its way through the memory
    typedef enum logic [1:0] {
        OWNER_NONE = 2'd0,
        OWNER_I    = 2'd1,
        OWNER_D    = 2'd2
    } owner_e;

    // one requester's access on one cycle
    // enable high means the request is present, write selects the direction
    typedef struct packed {
        logic                  enable;
        logic                  write;
        logic [`WORD_BITS-1:0] addr;
        logic [`WORD_BITS-1:0] data;
    } mem_req_t;

    // one returned word of a block fill and its slot in the block
    typedef struct packed {
        logic                           valid;
        logic [$clog2(`BLOCK_WORDS)-1:0] index;
        logic [`WORD_BITS-1:0]          data;
    } fill_t;

    // owner tag as it travels down the latency pipe next to the read data
    typedef struct packed {
        owner_e owner;
    } tagged_owner_t;

    // fill controller states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ISSUE = 2'd1,
        DRAIN = 2'd2,
        WRITE = 2'd3
    } fill_state_e;

endpackage

// ==== design/mem_latency_pipe.sv ====
// fixed-depth delay line for a payload and its valid bit; used for memory read data and the owner tag
`timescale 1ns/1ps

module mem_latency_pipe #(
    parameter type payload_t = logic [15:0],
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // stage 0 is loaded from the input, stage DEPTH-1 drives the output
    logic     valid_q [DEPTH];
    payload_t data_q  [DEPTH];

    // valid chain, cleared so nothing stale pops out after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // payload chain shifts every cycle
    // only meaningful where the matching valid is high
    always_ff @(posedge clk) begin
        data_q[0] <= in_data;
        for (int i = 1; i < DEPTH; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign out_valid = valid_q[DEPTH-1];
    assign out_data  = data_q[DEPTH-1];

endmodule

// ==== design/mem_array.sv ====
// pipelined main memory; one request per cycle, read data returns MEM_LATENCY cycles after acceptance
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_array (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_pkg::mem_req_t     req,
    output logic                  rd_valid,
    output logic [`WORD_BITS-1:0] rd_data
);

    import mem_pkg::*;

    localparam int unsigned DEPTH_WORDS = 1 << `MEM_ADDR_BITS;

    // storage, contents are undefined until written
    logic [`WORD_BITS-1:0] mem_q [DEPTH_WORDS];

    // only the low address bits select a word
    logic [`MEM_ADDR_BITS-1:0] word_addr;
    logic                      rd_accept;
    logic [`WORD_BITS-1:0]     rd_word;

    assign word_addr = req.addr[`MEM_ADDR_BITS-1:0];

    // writes complete at the edge ending the request cycle
    always_ff @(posedge clk) begin
        if (req.enable && req.write) begin
            mem_q[word_addr] <= req.data;
        end
    end

    // reads sample the array in the request cycle
    // a read one cycle after a write to the same word sees the new value
    assign rd_accept = req.enable && !req.write;
    assign rd_word   = mem_q[word_addr];

    // the latency pipe models the rest of the access time
    // writes never enter it, so they produce no valid
    mem_latency_pipe #(
        .payload_t (logic [`WORD_BITS-1:0]),
        .DEPTH     (`MEM_LATENCY)
    ) u_rd_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (rd_accept),
        .in_data   (rd_word),
        .out_valid (rd_valid),
        .out_data  (rd_data)
    );

endmodule

// ==== design/word_counter.sv ====
// clearable up-counter with an all-ones flag, counts issued or returned words of a block
`timescale 1ns/1ps

module word_counter #(
    parameter int WIDTH = 2
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             clear,
    input  logic             step,
    output logic [WIDTH-1:0] count,
    output logic             last
);

    // clear wins over step so a new block always starts at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (step) begin
            count <= count + 1'b1;
        end
    end

    // all ones marks the final word of the block
    assign last = &count;

endmodule

// ==== design/fill_ctrl.sv ====
// per-requester controller; turns a miss pulse into a block of word reads and a write pulse into one write
`timescale 1ns/1ps
`include "mem_macros.svh"

module fill_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  miss,
    input  logic                  write,
    input  logic [`WORD_BITS-1:0] miss_addr,
    input  logic [`WORD_BITS-1:0] write_addr,
    input  logic [`WORD_BITS-1:0] write_data,
    input  logic                  grant,
    input  logic                  rd_valid,
    input  logic [`WORD_BITS-1:0] rd_data,
    output mem_pkg::mem_req_t     req,
    output mem_pkg::fill_t        fill,
    output logic                  busy,
    output logic                  done
);

    import mem_pkg::*;

    localparam int unsigned IDX_BITS = $clog2(`BLOCK_WORDS);

    fill_state_e state_q;
    fill_state_e state_d;

    // block base for fills, word address for writes
    logic [`WORD_BITS-1:0] addr_q;
    logic [`WORD_BITS-1:0] wdata_q;

    logic [IDX_BITS-1:0] issue_cnt;
    logic [IDX_BITS-1:0] ret_cnt;
    logic                issue_last;
    logic                ret_last;
    logic                cnt_clear;
    logic                issue_step;
    logic                ret_step;

    // counters rest at zero while idle
    assign cnt_clear  = (state_q == IDLE);
    // an issue only counts once the arbiter takes it
    assign issue_step = (state_q == ISSUE) && grant;
    // returns can overlap issue under contention
    assign ret_step   = rd_valid && ((state_q == ISSUE) || (state_q == DRAIN));

    word_counter #(
        .WIDTH (IDX_BITS)
    ) u_issue_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (cnt_clear),
        .step  (issue_step),
        .count (issue_cnt),
        .last  (issue_last)
    );

    word_counter #(
        .WIDTH (IDX_BITS)
    ) u_ret_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (cnt_clear),
        .step  (ret_step),
        .count (ret_cnt),
        .last  (ret_last)
    );

    // starts are only looked at in IDLE, so pulses while busy are dropped
    // write-through beats a miss arriving on the same cycle
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (write) begin
                    state_d = WRITE;
                end else if (miss) begin
                    state_d = ISSUE;
                end
            end
            ISSUE: begin
                if (grant && issue_last) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                if (rd_valid && ret_last) begin
                    state_d = IDLE;
                end
            end
            WRITE: begin
                if (grant) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // capture the start arguments, miss address is aligned to its block
    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            if (write) begin
                addr_q  <= write_addr;
                wdata_q <= write_data;
            end else if (miss) begin
                addr_q <= {miss_addr[`WORD_BITS-1:IDX_BITS], {IDX_BITS{1'b0}}};
            end
        end
    end

    // request stays unchanged until granted
    // issue_cnt is zero in WRITE so the write address passes through as is
    always_comb begin
        req.enable = (state_q == ISSUE) || (state_q == WRITE);
        req.write  = (state_q == WRITE);
        req.addr   = addr_q + {{(`WORD_BITS - IDX_BITS){1'b0}}, issue_cnt};
        req.data   = wdata_q;
    end

    // fill slot comes from the return count, the memory gives no index
    always_comb begin
        fill.valid = rd_valid;
        fill.index = ret_cnt;
        fill.data  = rd_data;
    end

    assign busy = (state_q != IDLE);
    // done lines up with the last fill word or the granted write
    assign done = ((state_q == DRAIN) && rd_valid && ret_last)
               || ((state_q == WRITE) && grant);

endmodule

// ==== design/mem_arbiter.sv ====
// fixed-priority memory arbiter; d requests win, read valids are steered by an owner tag delayed with the data
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::mem_req_t i_req,
    input  mem_pkg::mem_req_t d_req,
    output logic              i_grant,
    output logic              d_grant,
    output mem_pkg::mem_req_t mem_req,
    input  logic              rd_valid,
    output logic              i_rd_valid,
    output logic              d_rd_valid
);

    import mem_pkg::*;

    tagged_owner_t grant_tag;
    tagged_owner_t ret_tag;
    logic          tag_valid;
    logic          rd_issue;
    owner_e        ret_owner;

    // d side always wins, i only gets idle cycles
    assign d_grant = d_req.enable;
    assign i_grant = i_req.enable && !d_req.enable;

    // forward the winner to the memory
    always_comb begin
        if (d_grant) begin
            mem_req = d_req;
        end else if (i_grant) begin
            mem_req = i_req;
        end else begin
            mem_req = '0;
        end
    end

    always_comb begin
        grant_tag.owner = OWNER_NONE;
        if (d_grant) begin
            grant_tag.owner = OWNER_D;
        end else if (i_grant) begin
            grant_tag.owner = OWNER_I;
        end
    end

    // only reads come back, so only reads are tagged
    assign rd_issue = mem_req.enable && !mem_req.write;

    // same depth as the memory read pipe, tag and data stay aligned
    // several reads from both sides may be in flight at once
    mem_latency_pipe #(
        .payload_t (tagged_owner_t),
        .DEPTH     (`MEM_LATENCY)
    ) u_owner_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (rd_issue),
        .in_data   (grant_tag),
        .out_valid (tag_valid),
        .out_data  (ret_tag)
    );

    // an empty pipe slot reads as no owner
    assign ret_owner = tag_valid ? ret_tag.owner : OWNER_NONE;

    // read data itself fans out to both controllers
    assign i_rd_valid = rd_valid && (ret_owner == OWNER_I);
    assign d_rd_valid = rd_valid && (ret_owner == OWNER_D);

endmodule

// ==== design/mem_subsys_top.sv ====
// memory subsystem top; two block-fill controllers share one pipelined memory through the arbiter
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_subsys_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_miss,
    input  logic [`WORD_BITS-1:0] i_miss_addr,
    input  logic                  d_miss,
    input  logic [`WORD_BITS-1:0] d_miss_addr,
    input  logic                  d_write,
    input  logic [`WORD_BITS-1:0] d_write_addr,
    input  logic [`WORD_BITS-1:0] d_write_data,
    output mem_pkg::fill_t        i_fill,
    output mem_pkg::fill_t        d_fill,
    output logic                  i_busy,
    output logic                  d_busy,
    output logic                  i_done,
    output logic                  d_done
);

    import mem_pkg::*;

    // controller requests and their grants
    mem_req_t i_req;
    mem_req_t d_req;
    logic     i_grant;
    logic     d_grant;

    // arbitrated memory port
    mem_req_t              mem_req;
    logic                  mem_rd_valid;
    logic [`WORD_BITS-1:0] mem_rd_data;

    // read valids steered per side
    logic i_rd_valid;
    logic d_rd_valid;

    // instruction side never writes
    fill_ctrl u_fill_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .miss       (i_miss),
        .write      (1'b0),
        .miss_addr  (i_miss_addr),
        .write_addr ('0),
        .write_data ('0),
        .grant      (i_grant),
        .rd_valid   (i_rd_valid),
        .rd_data    (mem_rd_data),
        .req        (i_req),
        .fill       (i_fill),
        .busy       (i_busy),
        .done       (i_done)
    );

    fill_ctrl u_fill_d (
        .clk        (clk),
        .rst_n      (rst_n),
        .miss       (d_miss),
        .write      (d_write),
        .miss_addr  (d_miss_addr),
        .write_addr (d_write_addr),
        .write_data (d_write_data),
        .grant      (d_grant),
        .rd_valid   (d_rd_valid),
        .rd_data    (mem_rd_data),
        .req        (d_req),
        .fill       (d_fill),
        .busy       (d_busy),
        .done       (d_done)
    );

    mem_arbiter u_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_req      (i_req),
        .d_req      (d_req),
        .i_grant    (i_grant),
        .d_grant    (d_grant),
        .mem_req    (mem_req),
        .rd_valid   (mem_rd_valid),
        .i_rd_valid (i_rd_valid),
        .d_rd_valid (d_rd_valid)
    );

    mem_array u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (mem_req),
        .rd_valid (mem_rd_valid),
        .rd_data  (mem_rd_data)
    );

endmodule

// ==== verification/mem_subsys_assert.sv ====
// arbiter protocol checks, attached to every mem_arbiter instance by the bind at the bottom
`timescale 1ns/1ps

module mem_subsys_assert (
    input logic              clk,
    input logic              rst_n,
    input mem_pkg::mem_req_t i_req,
    input mem_pkg::mem_req_t d_req,
    input logic              i_grant,
    input logic              d_grant,
    input logic              i_rd_valid,
    input logic              d_rd_valid
);

    // only one requester reaches the memory in a cycle
    a_grant_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(i_grant && d_grant)
    ) else $error("i_grant and d_grant high in the same cycle");

    // a returned word belongs to one side or to nobody
    a_rd_valid_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0({i_rd_valid, d_rd_valid})
    ) else $error("read valid routed to both sides");

    // d side has fixed priority and is never stalled
    a_d_priority: assert property (
        @(posedge clk) disable iff (!rst_n) d_grant == d_req.enable
    ) else $error("d_grant does not follow d_req.enable");

    // an i grant only goes to a present request
    a_i_grant_enable: assert property (
        @(posedge clk) disable iff (!rst_n) i_grant |-> i_req.enable
    ) else $error("i_grant without an i request");

endmodule

bind mem_arbiter mem_subsys_assert u_arb_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_req      (i_req),
    .d_req      (d_req),
    .i_grant    (i_grant),
    .d_grant    (d_grant),
    .i_rd_valid (i_rd_valid),
    .d_rd_valid (d_rd_valid)
);

// ==== verification/mem_subsys_tb.sv ====
// self-checking testbench for mem_subsys_top, checks fills and writes against a shadow memory
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_subsys_tb;

    import mem_pkg::*;

    localparam int IDX_BITS   = $clog2(`BLOCK_WORDS);
    localparam int FIRST_FILL = 1 + `MEM_LATENCY;
    localparam int LAST_FILL  = `BLOCK_WORDS + `MEM_LATENCY;
    // operations started over the whole run, writes and fills
    localparam int NUM_TESTS  = 32;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (`BLOCK_WORDS + `MEM_LATENCY + 4) * 2;

    logic                  clk;
    logic                  rst_n;
    logic                  i_miss;
    logic [`WORD_BITS-1:0] i_miss_addr;
    logic                  d_miss;
    logic [`WORD_BITS-1:0] d_miss_addr;
    logic                  d_write;
    logic [`WORD_BITS-1:0] d_write_addr;
    logic [`WORD_BITS-1:0] d_write_data;
    fill_t                 i_fill;
    fill_t                 d_fill;
    logic                  i_busy;
    logic                  d_busy;
    logic                  i_done;
    logic                  d_done;

    // shadow of every word written so far
    logic [`WORD_BITS-1:0] shadow [1 << `MEM_ADDR_BITS];
    logic [`WORD_BITS-1:0] blocks [4];
    logic [`WORD_BITS-1:0] i_words [`BLOCK_WORDS];
    logic [`WORD_BITS-1:0] i_base;
    logic [`WORD_BITS-1:0] d_base;
    logic [31:0]           lfsr_q;
    int                    i_seen;
    int                    d_seen;
    int                    i_done_count;
    int                    d_done_count;
    int                    error_count;
    int                    check_count;
    int                    cycle_count;

    mem_subsys_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_miss       (i_miss),
        .i_miss_addr  (i_miss_addr),
        .d_miss       (d_miss),
        .d_miss_addr  (d_miss_addr),
        .d_write      (d_write),
        .d_write_addr (d_write_addr),
        .d_write_data (d_write_data),
        .i_fill       (i_fill),
        .d_fill       (d_fill),
        .i_busy       (i_busy),
        .d_busy       (d_busy),
        .i_done       (i_done),
        .d_done       (d_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit, newest bit ends up in the lsb
    task automatic take_bits(input int n, output logic [`WORD_BITS-1:0] value);
        value = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = {value[`WORD_BITS-2:0], lfsr_q[0]};
        end
    endtask

    // reference model, memory only decodes the low address bits
    function automatic logic [`WORD_BITS-1:0] expected_word(input logic [`WORD_BITS-1:0] addr);
        return shadow[addr[`MEM_ADDR_BITS-1:0]];
    endfunction

    function automatic fill_t expected_fill(input logic [`WORD_BITS-1:0] base, input int seen);
        fill_t f;
        f.valid = 1'b1;
        f.index = seen[IDX_BITS-1:0];
        f.data  = expected_word(base + seen[`WORD_BITS-1:0]);
        return f;
    endfunction

    task automatic check_fill(input string name, input fill_t exp, input fill_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("error %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("error %s: expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_owner_word(input string name, input logic [`WORD_BITS-1:0] exp,
                                    input logic [`WORD_BITS-1:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("error %s: expected %h actual %h", name, exp, act);
        end
    endtask

    // compares every returned word, sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (rst_n) begin
            check_level("single side valid", 1'b0, i_fill.valid && d_fill.valid);
            if (i_fill.valid) begin
                check_fill("i fill word", expected_fill(i_base, i_seen), i_fill);
                i_words[i_fill.index] = i_fill.data;
                i_seen++;
            end
            if (d_fill.valid) begin
                check_fill("d fill word", expected_fill(d_base, d_seen), d_fill);
                d_seen++;
            end
            // done marks the last word of a block or a granted write
            if (i_done) begin
                check_level("i block length", 1'b1, i_seen == `BLOCK_WORDS);
                i_seen = 0;
                i_done_count++;
            end
            if (d_done) begin
                check_level("d block length", 1'b1, d_seen == `BLOCK_WORDS || d_seen == 0);
                d_seen = 0;
                d_done_count++;
            end
        end
    end

    // start pulses last one cycle, driven just after the edge
    task automatic pulse_i_miss(input logic [`WORD_BITS-1:0] addr, input logic record);
        i_miss      = 1'b1;
        i_miss_addr = addr;
        if (record) begin
            i_base = addr & ~16'(`BLOCK_WORDS - 1);
        end
        @(posedge clk);
        #5;
        i_miss = 1'b0;
    endtask

    task automatic pulse_d_miss(input logic [`WORD_BITS-1:0] addr);
        d_miss      = 1'b1;
        d_miss_addr = addr;
        d_base      = addr & ~16'(`BLOCK_WORDS - 1);
        @(posedge clk);
        #5;
        d_miss = 1'b0;
    endtask

    // write-through is granted at once, done shows up in the issue cycle
    task automatic write_word(input logic [`WORD_BITS-1:0] addr,
                              input logic [`WORD_BITS-1:0] data);
        d_write      = 1'b1;
        d_write_addr = addr;
        d_write_data = data;
        shadow[addr[`MEM_ADDR_BITS-1:0]] = data;
        @(posedge clk);
        #5;
        d_write = 1'b0;
        @(negedge clk);
        check_level("write done in issue cycle", 1'b1, d_done);
        @(posedge clk);
        #5;
    endtask

    task automatic wait_i_done();
        @(negedge clk);
        while (!i_done) begin
            @(negedge clk);
        end
        @(posedge clk);
        #5;
    endtask

    task automatic wait_d_done();
        @(negedge clk);
        while (!d_done) begin
            @(negedge clk);
        end
        @(posedge clk);
        #5;
    endtask

    task automatic wait_both_done();
        logic i_seen_done;
        logic d_seen_done;
        i_seen_done = 1'b0;
        d_seen_done = 1'b0;
        while (!(i_seen_done && d_seen_done)) begin
            @(negedge clk);
            i_seen_done = i_seen_done | i_done;
            d_seen_done = d_seen_done | d_done;
        end
        @(posedge clk);
        #5;
    endtask

    // watchdog sized from the number of operations
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin
        logic [`WORD_BITS-1:0] rnd;
        logic [`WORD_BITS-1:0] wdata;
        logic [`WORD_BITS-1:0] waddr;
        int                    cyc;
        int                    d_done_cycle;
        int                    done_before;
        rst_n        = 1'b0;
        i_miss       = 1'b0;
        i_miss_addr  = '0;
        d_miss       = 1'b0;
        d_miss_addr  = '0;
        d_write      = 1'b0;
        d_write_addr = '0;
        d_write_data = '0;
        lfsr_q       = 32'hd3a3;
        i_base       = '0;
        d_base       = '0;
        i_seen       = 0;
        d_seen       = 0;
        i_done_count = 0;
        d_done_count = 0;
        error_count  = 0;
        check_count  = 0;
        repeat (2) @(posedge clk);
        #5;
        rst_n = 1'b1;

        // everything quiet straight out of reset
        @(negedge clk);
        check_level("reset i busy", 1'b0, i_busy);
        check_level("reset d busy", 1'b0, d_busy);
        check_level("reset i done", 1'b0, i_done);
        check_level("reset d done", 1'b0, d_done);
        check_level("reset i valid", 1'b0, i_fill.valid);
        check_level("reset d valid", 1'b0, d_fill.valid);
        @(posedge clk);
        #5;

        // write-through of four whole blocks, then read each back on the d side
        for (int b = 0; b < 4; b++) begin
            take_bits(8, rnd);
            blocks[b] = {6'b0, rnd[7:0], 2'b00};
            for (int w = 0; w < `BLOCK_WORDS; w++) begin
                take_bits(16, wdata);
                write_word(blocks[b] + w[`WORD_BITS-1:0], wdata);
            end
        end
        for (int b = 0; b < 4; b++) begin
            pulse_d_miss(blocks[b]);
            wait_d_done();
        end
        // one done per write and one per block fill
        check_level("d done count", 1'b1, d_done_count == 4 * `BLOCK_WORDS + 4);

        // uncontended fill timing, cycle 1 is the one after the sampling edge
        pulse_i_miss(blocks[0], 1'b1);
        for (int c = 1; c <= LAST_FILL + 1; c++) begin
            @(negedge clk);
            check_level("fill timing valid", c >= FIRST_FILL && c <= LAST_FILL, i_fill.valid);
            check_level("fill timing done", c == LAST_FILL, i_done);
            check_level("fill timing busy", c <= LAST_FILL, i_busy);
        end
        @(posedge clk);
        #5;

        // both misses in one cycle, d runs at full speed and i waits
        i_miss      = 1'b1;
        i_miss_addr = blocks[1];
        i_base      = blocks[1];
        d_miss      = 1'b1;
        d_miss_addr = blocks[2];
        d_base      = blocks[2];
        @(posedge clk);
        #5;
        i_miss       = 1'b0;
        d_miss       = 1'b0;
        cyc          = 0;
        d_done_cycle = 0;
        do begin
            @(negedge clk);
            cyc++;
            if (d_done) begin
                d_done_cycle = cyc;
            end
            check_level("i busy until done", 1'b1, i_busy);
        end while (!i_done);
        check_level("d done uncontended", 1'b1, d_done_cycle == LAST_FILL);
        check_level("i done after d done", 1'b1, cyc > d_done_cycle);
        @(posedge clk);
        #5;

        // d miss lands while i reads are still in the memory pipe
        pulse_i_miss(blocks[3], 1'b1);
        @(posedge clk);
        #5;
        pulse_d_miss(blocks[0]);
        wait_both_done();

        // write immediately followed by an i fill of the same block
        take_bits(IDX_BITS, rnd);
        take_bits(16, wdata);
        waddr        = blocks[1] + {14'b0, rnd[1:0]};
        d_write      = 1'b1;
        d_write_addr = waddr;
        d_write_data = wdata;
        shadow[waddr[`MEM_ADDR_BITS-1:0]] = wdata;
        @(posedge clk);
        #5;
        d_write = 1'b0;
        pulse_i_miss(blocks[1], 1'b1);
        wait_i_done();
        check_owner_word("read after write", wdata, i_words[waddr[IDX_BITS-1:0]]);

        // a second miss while busy must be dropped
        done_before = i_done_count;
        pulse_i_miss(blocks[2], 1'b1);
        @(posedge clk);
        #5;
        pulse_i_miss(blocks[3], 1'b0);
        wait_i_done();
        repeat (LAST_FILL + 2) @(posedge clk);
        #5;
        check_level("ignored start done count", 1'b1, i_done_count == done_before + 1);
        check_level("ignored start idle", 1'b0, i_busy);

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
design/mem_pkg.sv
design/mem_latency_pipe.sv
design/mem_array.sv
design/word_counter.sv
design/fill_ctrl.sv
design/mem_arbiter.sv
design/mem_subsys_top.sv
verification/mem_subsys_assert.sv
verification/mem_subsys_tb.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/mem_pkg.sv
      - design/mem_latency_pipe.sv
      - design/mem_array.sv
      - design/word_counter.sv
      - design/fill_ctrl.sv
      - design/mem_arbiter.sv
      - design/mem_subsys_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/mem_subsys_assert.sv
      - verification/mem_subsys_tb.sv
